/* verilog/cpu_pkg.sv */
/*
 * Shared types and constants for the instruction-fetch front end.
 * Address, instruction and cache field widths, the NOP encoding,
 * cache and ROM sizes, and the fill FSM state encoding.
 * Modules pull these in with a wildcard import in their header.
 */
`default_nettype none

package cpu_pkg;

    localparam int WORD_W       = 32;                    // Address and data width
    localparam int OFS_W        = 2;                     // Byte offset inside a word

    localparam int ICACHE_LINES = 8;                     // One word per line
    localparam int IDX_W        = $clog2(ICACHE_LINES);  // Index from addr[4:2]
    localparam int TAG_W        = WORD_W - IDX_W - OFS_W; // Tag from addr[31:5]

    localparam int ROM_WORDS    = 32;                    // Image repeats every 128 bytes
    localparam int ROM_LAT      = 3;                     // Cycles from request to data

    typedef logic [WORD_W-1:0] word_t;   // Address or data word
    typedef logic [WORD_W-1:0] insn_t;   // Instruction word
    typedef logic [IDX_W-1:0]  idx_t;    // Cache line index
    typedef logic [TAG_W-1:0]  tag_t;    // Cache tag

    localparam word_t WORD_STEP = 32'd4;            // Sequential PC increment
    localparam insn_t ISA_NOP   = 32'h0000_0013;    // Bubble loaded on reset and redirect

    // Fill controller states, one miss handled at a time
    typedef enum logic [1:0] {
        FILL_IDLE,   // Watching for a miss
        FILL_WAIT,   // ROM read in flight
        FILL_WRITE   // Returned word goes into the cache
    } fill_state_t;

endpackage

`default_nettype wire

/* verilog/if_reg.sv */
/*
 * IF/ID pipeline register and fetch program counter.
 * Advances only when the cache has the word (data_rdy) and decode
 * is not stalled. Flush beats branch, branch beats sequential fetch.
 * A redirect or a stall leaves a NOP bubble with if_en low.
 */
`timescale 1ns/10ps
`default_nettype none

module if_reg import cpu_pkg::*; (
    input  wire logic  clk,        // Clock
    input  wire logic  reset,      // Sync reset, active high
    input  wire insn_t insn,       // Word read from the cache
    input  wire logic  stall,      // Decode stall
    input  wire logic  data_rdy,   // Cache hit on if_pc
    input  wire logic  flush,      // Flush request
    input  wire word_t new_pc,     // Flush target
    input  wire logic  br_taken,   // Branch taken
    input  wire word_t br_addr,    // Branch target
    output word_t      pc,         // PC of the latched instruction
    output word_t      if_pc,      // Next fetch address
    output insn_t      if_insn,    // Latched instruction
    output logic       if_en       // Pipeline valid
);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= '0;
            if_pc   <= '0;
            if_insn <= ISA_NOP;
            if_en   <= 1'b0;
        end else if (data_rdy) begin      // Everything holds during a miss
            if (!stall) begin
                if (flush) begin
                    if_pc   <= new_pc;    // Flush wins
                    if_insn <= ISA_NOP;
                    if_en   <= 1'b0;
                end else if (br_taken) begin
                    if_pc   <= br_addr;   // Redirect to branch target
                    if_insn <= ISA_NOP;
                    if_en   <= 1'b0;
                end else begin
                    pc      <= if_pc;     // Hand the hit word to decode
                    if_pc   <= if_pc + WORD_STEP;
                    if_insn <= insn;
                    if_en   <= 1'b1;
                end
            end else begin
                if_en <= 1'b0;            // Bubble, pc and insn hold
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/icache_array.sv */
/*
 * Direct-mapped instruction cache storage, one word per line.
 * Lookup is combinational: index from addr[4:2], tag from
 * addr[31:5], hit when the line is valid and the tags agree.
 * A fill writes tag and data at the clock edge and sets valid.
 */
`timescale 1ns/10ps
`default_nettype none

module icache_array import cpu_pkg::*; (
    input  wire logic  clk,          // Clock
    input  wire logic  reset,        // Sync reset, clears valid bits
    input  wire word_t lookup_addr,  // Fetch address
    input  wire logic  fill_we,      // Line write strobe
    input  wire word_t fill_addr,    // Address of the filled word
    input  wire insn_t fill_data,    // Filled word
    output logic       hit,          // Lookup hit
    output insn_t      rd_insn       // Word at the lookup index
);

    logic [ICACHE_LINES-1:0] valid;   // Per-line valid
    tag_t  tag_mem  [ICACHE_LINES];   // Tags
    insn_t data_mem [ICACHE_LINES];   // Instruction words

    idx_t lk_idx;   // Lookup index
    tag_t lk_tag;   // Lookup tag
    idx_t wr_idx;   // Fill index
    tag_t wr_tag;   // Fill tag

    assign lk_idx = lookup_addr[OFS_W +: IDX_W];
    assign lk_tag = lookup_addr[OFS_W + IDX_W +: TAG_W];
    assign wr_idx = fill_addr[OFS_W +: IDX_W];
    assign wr_tag = fill_addr[OFS_W + IDX_W +: TAG_W];

    assign hit     = valid[lk_idx] && (tag_mem[lk_idx] == lk_tag);
    assign rd_insn = data_mem[lk_idx];   // Only meaningful with hit

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (fill_we) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    // Tag and data storage
    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[wr_idx]  <= wr_tag;    // Replaces any old tag
            data_mem[wr_idx] <= fill_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/icache_ctrl.sv */
/*
 * Instruction cache fill controller.
 * A miss seen in FILL_IDLE sends one ROM request for the fetch
 * address, FILL_WAIT waits for rom_valid, and FILL_WRITE writes
 * the returned word into the cache for one cycle.
 * Miss to hit takes ROM_LAT + 2 cycles; only one read is in flight.
 */
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl import cpu_pkg::*; (
    input  wire logic  clk,        // Clock
    input  wire logic  reset,      // Sync reset, active high
    input  wire word_t fetch_pc,   // Address being looked up
    input  wire logic  hit,        // Cache hit on fetch_pc
    input  wire logic  rom_valid,  // ROM data strobe
    input  wire insn_t rom_data,   // ROM read data
    output logic       rom_req,    // One-cycle read request
    output word_t      rom_addr,   // Read address
    output logic       fill_we,    // Cache line write
    output word_t      fill_addr,  // Line address to write
    output insn_t      fill_data   // Word to write
);

    fill_state_t state;       // Fill FSM state
    word_t       miss_addr;   // Address of the word being fetched
    insn_t       miss_data;   // Word returned by the ROM

    // Request goes out in the same cycle the miss shows up
    assign rom_req   = (state == FILL_IDLE) && !hit;
    assign rom_addr  = fetch_pc;
    assign fill_we   = (state == FILL_WRITE);   // One cycle per fill
    assign fill_addr = miss_addr;
    assign fill_data = miss_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FILL_IDLE;
        end else begin
            case (state)
                FILL_IDLE: begin
                    if (!hit) begin
                        state <= FILL_WAIT;    // Request issued this cycle
                    end
                end
                FILL_WAIT: begin
                    if (rom_valid) begin
                        state <= FILL_WRITE;   // Data captured below
                    end
                end
                FILL_WRITE: begin
                    state <= FILL_IDLE;        // Line valid from next cycle
                end
                default: begin
                    state <= FILL_IDLE;
                end
            endcase
        end
    end

    // Miss address and returned word
    always_ff @(posedge clk) begin
        if (rom_req) begin
            miss_addr <= fetch_pc;
        end
        if ((state == FILL_WAIT) && rom_valid) begin
            miss_data <= rom_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/insn_rom.sv */
/*
 * Instruction ROM with a fixed read latency.
 * Contents come from the hex image at start of simulation.
 * The word at addr[6:2] is read on rom_req and comes back with
 * rom_valid exactly ROM_LAT cycles later, through a shift pipe.
 */
`timescale 1ns/10ps
`default_nettype none

module insn_rom import cpu_pkg::*; (
    input  wire logic  clk,        // Clock
    input  wire logic  reset,      // Sync reset, clears the valid pipe
    input  wire logic  rom_req,    // Read request
    input  wire word_t rom_addr,   // Byte address
    output logic       rom_valid,  // Data strobe
    output insn_t      rom_data    // Read data
);

    localparam string ROM_FILE = "insn_rom.hex";     // Program image
    localparam int    ROM_AW   = $clog2(ROM_WORDS);  // Word address bits

    insn_t              rom_mem [ROM_WORDS];   // ROM contents
    logic [ROM_AW-1:0]  rd_idx;                // Word index
    logic [ROM_LAT-1:0] vld_sr;                // Request delay line
    insn_t              data_sr [ROM_LAT];     // Data delay line

    initial begin
        $readmemh(ROM_FILE, rom_mem);
    end

    assign rd_idx    = rom_addr[OFS_W +: ROM_AW];   // Wraps every 128 bytes
    assign rom_valid = vld_sr[ROM_LAT-1];
    assign rom_data  = data_sr[ROM_LAT-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[ROM_LAT-2:0], rom_req};
        end
    end

    // Data follows the valid bit stage for stage
    always_ff @(posedge clk) begin
        data_sr[0] <= rom_mem[rd_idx];
        for (int i = 1; i < ROM_LAT; i++) begin
            data_sr[i] <= data_sr[i-1];
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_unit.sv */
/*
 * Top of the instruction-fetch front end.
 * Joins the IF/ID register, the direct-mapped instruction cache,
 * its fill controller and the instruction ROM. Decode sees pc,
 * if_insn and if_en; insn_ready is the cache hit, which shows
 * the cycles in which stall and redirect requests are taken.
 */
`timescale 1ns/10ps
`default_nettype none

module fetch_unit import cpu_pkg::*; (
    input  wire logic  clk,         // Clock
    input  wire logic  reset,       // Sync reset, active high
    input  wire logic  stall,       // Back-pressure from decode
    input  wire logic  flush,       // Pipeline flush request
    input  wire word_t new_pc,      // Flush target
    input  wire logic  br_taken,    // Branch taken request
    input  wire word_t br_addr,     // Branch target
    output word_t      pc,          // Address of if_insn
    output insn_t      if_insn,     // Instruction to decode
    output logic       if_en,       // if_insn is valid
    output logic       insn_ready   // Cache hit this cycle
);

    word_t fetch_pc;    // Address being looked up
    logic  hit;         // Lookup hit
    insn_t rd_insn;     // Word from the cache
    logic  rom_req;     // Read request to ROM
    word_t rom_addr;    // ROM read address
    logic  rom_valid;   // ROM data strobe
    insn_t rom_data;    // ROM read data
    logic  fill_we;     // Cache line write
    word_t fill_addr;   // Line address to fill
    insn_t fill_data;   // Word to fill

    assign insn_ready = hit;

    if_reg u_if_reg (
        .clk      (clk),
        .reset    (reset),
        .insn     (rd_insn),
        .stall    (stall),
        .data_rdy (hit),
        .flush    (flush),
        .new_pc   (new_pc),
        .br_taken (br_taken),
        .br_addr  (br_addr),
        .pc       (pc),
        .if_pc    (fetch_pc),
        .if_insn  (if_insn),
        .if_en    (if_en)
    );

    icache_array u_icache_array (
        .clk         (clk),
        .reset       (reset),
        .lookup_addr (fetch_pc),
        .fill_we     (fill_we),
        .fill_addr   (fill_addr),
        .fill_data   (fill_data),
        .hit         (hit),
        .rd_insn     (rd_insn)
    );

    icache_ctrl u_icache_ctrl (
        .clk       (clk),
        .reset     (reset),
        .fetch_pc  (fetch_pc),
        .hit       (hit),
        .rom_valid (rom_valid),
        .rom_data  (rom_data),
        .rom_req   (rom_req),
        .rom_addr  (rom_addr),
        .fill_we   (fill_we),
        .fill_addr (fill_addr),
        .fill_data (fill_data)
    );

    insn_rom u_insn_rom (
        .clk       (clk),
        .reset     (reset),
        .rom_req   (rom_req),
        .rom_addr  (rom_addr),
        .rom_valid (rom_valid),
        .rom_data  (rom_data)
    );

endmodule

`default_nettype wire

/* sim/tb_fetch_unit.sv */
/*
 * Directed testbench for the instruction-fetch front end.
 * A collector checks every delivered instruction against a model
 * loaded from the ROM image; test tasks drive stalls and redirects.
 * Run from the project root so the hex image is found.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_unit import cpu_pkg::*; ();

    localparam int    CLK_PERIOD      = 8;
    localparam int    RESET_CYCLES    = 8;
    localparam string MODEL_FILE      = "insn_rom.hex";   // Same image as the ROM
    localparam int    MODEL_AW        = $clog2(ROM_WORDS);
    localparam int    STALL_CYCLES    = 64;              // Length of random stall run
    localparam int    MISS_CYCLES     = ROM_LAT + 3;     // Worst case per delivery
    localparam int    TEST_CYCLES     = 140;             // Deliveries plus stall cycles
    localparam int    WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES * MISS_CYCLES + 300;
    localparam logic [31:0] LFSR_SEED = 32'h9e34_8fd7;

    logic  clk;          // Clock
    logic  reset;        // Sync reset
    logic  stall;        // Decode stall
    logic  flush;        // Flush request
    word_t new_pc;       // Flush target
    logic  br_taken;     // Branch request
    word_t br_addr;      // Branch target
    word_t pc;           // Delivered pc
    insn_t if_insn;      // Delivered instruction
    logic  if_en;        // Delivery valid
    logic  insn_ready;   // Cache hit

    insn_t       model_mem [ROM_WORDS];   // Reference program image
    word_t       exp_pc      = '0;        // Next pc decode should see
    int          deliv_count = 0;         // Instructions delivered
    int          ready_rises = 0;         // Ends of cache misses
    int          stall_holds = 0;         // Stalled cycles with a hit
    int          errors      = 0;
    logic [31:0] lfsr;
    logic        ready_prev  = 1'b0;      // Values of the previous cycle
    logic        stall_prev  = 1'b0;
    logic        reset_prev  = 1'b1;
    word_t       pc_prev     = '0;

    fetch_unit dut0 (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .flush      (flush),
        .new_pc     (new_pc),
        .br_taken   (br_taken),
        .br_addr    (br_addr),
        .pc         (pc),
        .if_insn    (if_insn),
        .if_en      (if_en),
        .insn_ready (insn_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Galois form, one step per bit
    function automatic logic rand_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    // Word at byte address a is model word (a / 4) mod 32
    function automatic insn_t expected_insn(input word_t addr);
        logic [MODEL_AW-1:0] idx;
        idx = MODEL_AW'((addr / 4) % ROM_WORDS);
        return model_mem[idx];
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    // Sampled mid-cycle, away from the clock edge and the input changes
    initial begin
        forever begin
            @(negedge clk);
            if (!reset && !reset_prev) begin
                if (insn_ready && !ready_prev) begin
                    ready_rises++;                         // A miss just ended
                end
                if (if_en && ready_prev) begin             // Loaded at the last edge
                    assert (pc == exp_pc && if_insn == expected_insn(exp_pc)) else begin
                        report_error($sformatf("got pc %h insn %h, expected pc %h insn %h",
                            pc, if_insn, exp_pc, expected_insn(exp_pc)));
                    end
                    deliv_count++;
                    exp_pc = exp_pc + WORD_STEP;
                end
                if (stall_prev && ready_prev) begin        // Stall taken last edge
                    stall_holds++;
                    assert (!if_en && pc == pc_prev) else begin
                        report_error($sformatf("stall not held, if_en %b pc %h was %h",
                            if_en, pc, pc_prev));
                    end
                end
            end
            ready_prev = insn_ready;
            stall_prev = stall;
            reset_prev = reset;
            pc_prev    = pc;
        end
    end

    // Called at drive time, returns at drive time
    task automatic wait_deliveries(input int n);
        int target;
        target = deliv_count + n;
        while (deliv_count < target) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic freeze_fetch();
        stall = 1'b1;
        while (!insn_ready) begin   // Pending fill still completes
            @(posedge clk);
            #1;
        end
    endtask

    // Holds the request until a cycle with a hit and no stall
    task automatic take_redirect(input logic do_flush, input word_t flush_pc,
                                 input logic do_branch, input word_t branch_pc,
                                 input logic expect_hit);
        logic taken;
        taken    = 1'b0;
        flush    = do_flush;
        new_pc   = flush_pc;
        br_taken = do_branch;
        br_addr  = branch_pc;
        stall    = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = insn_ready && !stall;
        end
        @(posedge clk);                               // Edge that takes it
        #1;
        flush    = 1'b0;
        br_taken = 1'b0;
        exp_pc   = do_flush ? flush_pc : branch_pc;   // Flush wins
        @(negedge clk);
        assert (!if_en && insn_ready == expect_hit) else begin
            report_error($sformatf("after redirect if_en %b insn_ready %b, expected 0 and %b",
                if_en, insn_ready, expect_hit));
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_reset_state();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        assert (!if_en && pc == '0 && if_insn == ISA_NOP && !insn_ready) else begin
            report_error($sformatf("after reset if_en %b pc %h insn %h insn_ready %b",
                if_en, pc, if_insn, insn_ready));
        end
        @(posedge clk);
        #1;
    endtask

    task automatic test_cold_fetch();
        int rises0;
        rises0 = ready_rises;
        wait_deliveries(16);
        assert (ready_rises - rises0 == 16) else begin
            report_error($sformatf("%0d misses for 16 cold words", ready_rises - rises0));
        end
        freeze_fetch();
    endtask

    task automatic test_warm_fetch();
        take_redirect(1'b1, 32'h0, 1'b0, 32'h0, 1'b0);   // Line 0 holds 64 by now
        wait_deliveries(ICACHE_LINES - 1);
        freeze_fetch();                                  // Fill of 28 lands meanwhile
        take_redirect(1'b1, 32'h0, 1'b0, 32'h0, 1'b1);
        for (int i = 0; i < ICACHE_LINES; i++) begin
            @(negedge clk);
            assert (if_en && pc == word_t'(i * 4)) else begin
                report_error($sformatf("warm fetch gap, if_en %b pc %h", if_en, pc));
            end
        end
        @(posedge clk);
        #1;
        freeze_fetch();
    endtask

    task automatic test_stall();
        int count0;
        int holds0;
        take_redirect(1'b1, 32'h8, 1'b0, 32'h0, 1'b1);   // Lines 1 to 7 still warm
        count0 = deliv_count;
        holds0 = stall_holds;
        repeat (STALL_CYCLES) begin
            stall = rand_bit();
            @(posedge clk);
            #1;
        end
        freeze_fetch();
        assert (deliv_count > count0 && stall_holds > holds0) else begin
            report_error("random stall run gave no delivery or no stalled hit");
        end
    endtask

    task automatic test_redirect_priority();
        take_redirect(1'b0, 32'h0, 1'b1, 32'h200, 1'b0);
        wait_deliveries(4);
        freeze_fetch();
        take_redirect(1'b0, 32'h0, 1'b1, 32'h204, 1'b1);   // Branch alone
        @(negedge clk);
        assert (if_en && pc == 32'h204) else begin
            report_error($sformatf("branch target not delivered, pc %h", pc));
        end
        @(posedge clk);
        #1;
        freeze_fetch();
        take_redirect(1'b1, 32'h200, 1'b1, 32'h300, 1'b1);   // Both in one cycle
        @(negedge clk);
        assert (if_en && pc == 32'h200) else begin
            report_error($sformatf("flush did not win over branch, pc %h", pc));
        end
        @(posedge clk);
        #1;
        freeze_fetch();
    endtask

    task automatic test_conflict_wrap();
        take_redirect(1'b0, 32'h0, 1'b1, 32'h80, 1'b0);   // Index 0, new tag
        wait_deliveries(ICACHE_LINES);
        freeze_fetch();
        take_redirect(1'b0, 32'h0, 1'b1, 32'h0, 1'b0);    // Evicted, so a miss
        wait_deliveries(4);
        freeze_fetch();
    endtask

    initial begin
        reset    = 1'b1;
        stall    = 1'b0;
        flush    = 1'b0;
        new_pc   = '0;
        br_taken = 1'b0;
        br_addr  = '0;
        lfsr     = LFSR_SEED;
        $readmemh(MODEL_FILE, model_mem);
        check_reset_state();
        test_cold_fetch();
        test_warm_fetch();
        test_stall();
        test_redirect_priority();
        test_conflict_wrap();
        $display("Run complete: %0d instructions checked, %0d errors", deliv_count, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the DUT stopped making progress",
            WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* fetch_unit.f */
verilog/cpu_pkg.sv
verilog/if_reg.sv
verilog/icache_array.sv
verilog/icache_ctrl.sv
verilog/insn_rom.sv
verilog/fetch_unit.sv
sim/tb_fetch_unit.sv

/* Makefile */
# Verilator flow for the instruction-fetch front end

TOOL       = verilator
TOP        = tb_fetch_unit
FILELIST   = fetch_unit.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* insn_rom.hex */
// One 32-bit instruction word per line in hex, ROM word 0 first
00500093
00a00113
002081b3
40208233
0020f2b3
0020e333
0020c3b3
00209433
0020d4b3
00112023
00012503
00150513
fff50513
00351593
4035d613
0015a693
00b62733
12345737
00001797
00c78793
00f70833
01000893
00208463
fe209ee3
0080006f
000780e7
01c12903
01212e23
00a4c993
0ff9fa13
014a6ab3
00000073
